// ==== Bender.yml ====
package:
  name: rename

sources:
  - design/rename_pkg.sv
  - design/rename_sequencer.sv
  - design/fill_counter.sv
  - design/free_list.sv
  - design/map_table.sv
  - design/rename_unit.sv
  - target: test
    files:
      - verification/rename_tb.sv

// ==== design/fill_counter.sv ====
`default_nettype none

module fill_counter #(
	parameter int NUM_PHYS_REGS = 64
) (
	input logic clock,
	input logic reset,
	input logic fill_enable,
	output rename_pkg::phys_tag_t fill_tag,
	output logic fill_done
);
	import rename_pkg::*;

	localparam int FREE_DEPTH = NUM_PHYS_REGS - ARCH_REGS;
	localparam phys_tag_t FIRST_TAG = PHYS_W'(ARCH_REGS);
	localparam phys_tag_t LAST_TAG = PHYS_W'(ARCH_REGS + FREE_DEPTH - 1);

	phys_tag_t count_q;
	logic done_q;
	logic last_issue;

	assign last_issue = fill_enable && !done_q && (count_q == LAST_TAG);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count_q <= FIRST_TAG;
			done_q <= 1'b0;
		end
		else if (fill_enable && !done_q)
		begin
			if (count_q == LAST_TAG)
			begin
				done_q <= 1'b1;
			end
			else
			begin
				count_q <= count_q + 1'b1;
			end
		end
	end

	assign fill_tag = count_q;

	// Done shows up in the cycle of the last push, so the sequencer leaves fill on that edge.
	assign fill_done = done_q || last_issue;

endmodule

`default_nettype wire

// ==== design/free_list.sv ====
`default_nettype none

module free_list #(
	parameter int NUM_PHYS_REGS = 64
) (
	input logic clock,
	input logic reset,
	input logic fill_enable,
	input rename_pkg::phys_tag_t fill_tag,
	input logic pop0,
	input logic pop1,
	input logic [1:0] retire_valid,
	input rename_pkg::phys_tag_t retire_tag0,
	input rename_pkg::phys_tag_t retire_tag1,
	output rename_pkg::phys_tag_t free_tag0,
	output rename_pkg::phys_tag_t free_tag1,
	output logic [7:0] free_count
);
	import rename_pkg::*;

	localparam int FREE_DEPTH = NUM_PHYS_REGS - ARCH_REGS;
	localparam int PTR_W = $clog2(FREE_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;

	phys_tag_t ring [FREE_DEPTH];
	ptr_t head_q;
	ptr_t tail_q;
	logic [7:0] count_q;

	logic push0;
	logic push1;
	phys_tag_t push_tag0;
	logic [1:0] pop_num;
	logic [1:0] push_num;

	// Pointer step with wrap, since the depth is not always a power of two.
	function automatic ptr_t ptr_add(input ptr_t ptr, input logic [1:0] step);
		int sum;
		sum = int'(ptr) + int'(step);
		if (sum >= FREE_DEPTH)
		begin
			sum = sum - FREE_DEPTH;
		end
		return ptr_t'(sum);
	endfunction

	// While filling, the counter owns the first write port and retires are not taken.
	assign push0 = fill_enable || retire_valid[0];
	assign push_tag0 = fill_enable ? fill_tag : retire_tag0;
	assign push1 = !fill_enable && retire_valid[1];

	assign pop_num = {1'b0, pop0} + {1'b0, pop1};
	assign push_num = {1'b0, push0} + {1'b0, push1};

	always_ff @(posedge clock)
	begin
		if (push0)
		begin
			ring[tail_q] <= push_tag0;
		end
		if (push1)
		begin
			ring[ptr_add(tail_q, {1'b0, push0})] <= retire_tag1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end
		else
		begin
			head_q <= ptr_add(head_q, pop_num);
			tail_q <= ptr_add(tail_q, push_num);
			count_q <= count_q + 8'(push_num) - 8'(pop_num);
		end
	end

	assign free_tag0 = ring[head_q];
	assign free_tag1 = ring[ptr_add(head_q, 2'd1)];
	assign free_count = count_q;

endmodule

`default_nettype wire

// ==== design/map_table.sv ====
`default_nettype none

module map_table #(
	parameter int CDB_WIDTH = 6
) (
	input logic clock,
	input logic reset,
	input logic fire0,
	input logic fire1,
	input logic uses_ra_0,
	input logic uses_rb_0,
	input rename_pkg::arch_reg_t ra_0,
	input rename_pkg::arch_reg_t rb_0,
	input rename_pkg::arch_reg_t dest_0,
	input logic uses_ra_1,
	input logic uses_rb_1,
	input rename_pkg::arch_reg_t ra_1,
	input rename_pkg::arch_reg_t rb_1,
	input rename_pkg::arch_reg_t dest_1,
	input rename_pkg::phys_tag_t free_tag0,
	input rename_pkg::phys_tag_t free_tag1,
	input logic [CDB_WIDTH-1:0] cdb_valid,
	input rename_pkg::phys_tag_t [CDB_WIDTH-1:0] cdb_phys,
	input rename_pkg::arch_reg_t [CDB_WIDTH-1:0] cdb_arch,
	output rename_pkg::phys_tag_t src_a_tag_0,
	output logic src_a_ready_0,
	output rename_pkg::phys_tag_t src_b_tag_0,
	output logic src_b_ready_0,
	output rename_pkg::phys_tag_t src_a_tag_1,
	output logic src_a_ready_1,
	output rename_pkg::phys_tag_t src_b_tag_1,
	output logic src_b_ready_1,
	output rename_pkg::phys_tag_t new_tag_0,
	output rename_pkg::phys_tag_t new_tag_1,
	output rename_pkg::phys_tag_t old_tag_0,
	output rename_pkg::phys_tag_t old_tag_1
);
	import rename_pkg::*;

	phys_tag_t map_q [ARCH_REGS];
	logic [ARCH_REGS-1:0] ready_q;
	logic [ARCH_REGS-1:0] ready_next;

	logic byp_a_1;
	logic byp_b_1;

	// Slot 1 pops the head entry itself when slot 0 is not renamed this cycle.
	assign new_tag_0 = free_tag0;
	assign new_tag_1 = fire0 ? free_tag1 : free_tag0;

	always_comb
	begin
		ready_next = ready_q;
		for (int lane = 0; lane < CDB_WIDTH; lane++)
		begin
			// A stale tag means the register was renamed again, so it stays not ready.
			if (cdb_valid[lane] && map_q[cdb_arch[lane]] == cdb_phys[lane])
			begin
				ready_next[cdb_arch[lane]] = 1'b1;
			end
		end
		// Clears come last so a new mapping is never marked ready by an old result.
		if (fire0)
		begin
			ready_next[dest_0] = 1'b0;
		end
		if (fire1)
		begin
			ready_next[dest_1] = 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < ARCH_REGS; i++)
			begin
				map_q[i] <= PHYS_W'(i);
			end
			ready_q <= '1;
		end
		else
		begin
			ready_q <= ready_next;
			if (fire0)
			begin
				map_q[dest_0] <= new_tag_0;
			end
			// Slot 1 is younger, so on equal destinations its tag is the one kept.
			if (fire1)
			begin
				map_q[dest_1] <= new_tag_1;
			end
		end
	end

	assign src_a_tag_0 = uses_ra_0 ? map_q[ra_0] : '0;
	assign src_a_ready_0 = uses_ra_0 ? ready_q[ra_0] : 1'b1;
	assign src_b_tag_0 = uses_rb_0 ? map_q[rb_0] : '0;
	assign src_b_ready_0 = uses_rb_0 ? ready_q[rb_0] : 1'b1;

	// Slot 1 must see the rename done by slot 0 in the same group.
	assign byp_a_1 = fire0 && (ra_1 == dest_0);
	assign byp_b_1 = fire0 && (rb_1 == dest_0);

	assign src_a_tag_1 = !uses_ra_1 ? '0 : (byp_a_1 ? new_tag_0 : map_q[ra_1]);
	assign src_a_ready_1 = !uses_ra_1 ? 1'b1 : (!byp_a_1 && ready_q[ra_1]);
	assign src_b_tag_1 = !uses_rb_1 ? '0 : (byp_b_1 ? new_tag_0 : map_q[rb_1]);
	assign src_b_ready_1 = !uses_rb_1 ? 1'b1 : (!byp_b_1 && ready_q[rb_1]);

	assign old_tag_0 = map_q[dest_0];
	assign old_tag_1 = (fire0 && dest_1 == dest_0) ? new_tag_0 : map_q[dest_1];

endmodule

`default_nettype wire

// ==== design/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

	// Architectural register file size and index width.
	localparam int ARCH_REGS = 32;
	localparam int ARCH_W = 5;

	// Physical tags are wide enough for up to 128 registers.
	localparam int PHYS_W = 7;

	typedef logic [ARCH_W-1:0] arch_reg_t;
	typedef logic [PHYS_W-1:0] phys_tag_t;

	// The stage first loads the free list, then renames.
	typedef enum logic
	{
		SEQ_FILL,
		SEQ_RUN
	} seq_state_e;

endpackage

`default_nettype wire

// ==== design/rename_sequencer.sv ====
`default_nettype none

module rename_sequencer (
	input logic clock,
	input logic reset,
	input logic slot_valid_0,
	input logic slot_valid_1,
	input logic [7:0] free_count,
	input logic fill_done,
	output logic fill_enable,
	output logic dispatch_ready,
	output logic fire0,
	output logic fire1
);
	import rename_pkg::*;

	seq_state_e state_q;
	seq_state_e state_next;

	always_comb
	begin
		state_next = state_q;
		if (state_q == SEQ_FILL && fill_done)
		begin
			state_next = SEQ_RUN;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state_q <= SEQ_FILL;
		end
		else
		begin
			state_q <= state_next;
		end
	end

	assign fill_enable = (state_q == SEQ_FILL);

	// Two free tags must be on hand so that a full pair can always be renamed.
	assign dispatch_ready = (state_q == SEQ_RUN) && (free_count >= 8'd2);

	// These strobes are the only place where dispatch_ready gates a slot.
	assign fire0 = slot_valid_0 && dispatch_ready;
	assign fire1 = slot_valid_1 && dispatch_ready;

endmodule

`default_nettype wire

// ==== design/rename_unit.sv ====
`default_nettype none

module rename_unit #(
	parameter int NUM_PHYS_REGS = 64,
	parameter int CDB_WIDTH = 6
) (
	input logic clock,
	input logic reset,
	input logic slot_valid_0,
	input logic uses_ra_0,
	input logic uses_rb_0,
	input rename_pkg::arch_reg_t ra_0,
	input rename_pkg::arch_reg_t rb_0,
	input rename_pkg::arch_reg_t dest_0,
	input logic slot_valid_1,
	input logic uses_ra_1,
	input logic uses_rb_1,
	input rename_pkg::arch_reg_t ra_1,
	input rename_pkg::arch_reg_t rb_1,
	input rename_pkg::arch_reg_t dest_1,
	input logic [CDB_WIDTH-1:0] cdb_valid,
	input rename_pkg::phys_tag_t [CDB_WIDTH-1:0] cdb_phys,
	input rename_pkg::arch_reg_t [CDB_WIDTH-1:0] cdb_arch,
	input logic [1:0] retire_valid,
	input rename_pkg::phys_tag_t retire_tag0,
	input rename_pkg::phys_tag_t retire_tag1,
	output logic dispatch_ready,
	output rename_pkg::phys_tag_t src_a_tag_0,
	output logic src_a_ready_0,
	output rename_pkg::phys_tag_t src_b_tag_0,
	output logic src_b_ready_0,
	output rename_pkg::phys_tag_t new_tag_0,
	output rename_pkg::phys_tag_t old_tag_0,
	output rename_pkg::phys_tag_t src_a_tag_1,
	output logic src_a_ready_1,
	output rename_pkg::phys_tag_t src_b_tag_1,
	output logic src_b_ready_1,
	output rename_pkg::phys_tag_t new_tag_1,
	output rename_pkg::phys_tag_t old_tag_1
);
	import rename_pkg::*;

	logic fill_enable;
	logic fill_done;
	phys_tag_t fill_tag;
	phys_tag_t free_tag0;
	phys_tag_t free_tag1;
	logic [7:0] free_count;
	logic fire0;
	logic fire1;

	rename_sequencer u_sequencer (
		.clock(clock),
		.reset(reset),
		.slot_valid_0(slot_valid_0),
		.slot_valid_1(slot_valid_1),
		.free_count(free_count),
		.fill_done(fill_done),
		.fill_enable(fill_enable),
		.dispatch_ready(dispatch_ready),
		.fire0(fire0),
		.fire1(fire1)
	);

	fill_counter #(
		.NUM_PHYS_REGS(NUM_PHYS_REGS)
	) u_fill_counter (
		.clock(clock),
		.reset(reset),
		.fill_enable(fill_enable),
		.fill_tag(fill_tag),
		.fill_done(fill_done)
	);

	free_list #(
		.NUM_PHYS_REGS(NUM_PHYS_REGS)
	) u_free_list (
		.clock(clock),
		.reset(reset),
		.fill_enable(fill_enable),
		.fill_tag(fill_tag),
		.pop0(fire0),
		.pop1(fire1),
		.retire_valid(retire_valid),
		.retire_tag0(retire_tag0),
		.retire_tag1(retire_tag1),
		.free_tag0(free_tag0),
		.free_tag1(free_tag1),
		.free_count(free_count)
	);

	map_table #(
		.CDB_WIDTH(CDB_WIDTH)
	) u_map_table (
		.clock(clock),
		.reset(reset),
		.fire0(fire0),
		.fire1(fire1),
		.uses_ra_0(uses_ra_0),
		.uses_rb_0(uses_rb_0),
		.ra_0(ra_0),
		.rb_0(rb_0),
		.dest_0(dest_0),
		.uses_ra_1(uses_ra_1),
		.uses_rb_1(uses_rb_1),
		.ra_1(ra_1),
		.rb_1(rb_1),
		.dest_1(dest_1),
		.free_tag0(free_tag0),
		.free_tag1(free_tag1),
		.cdb_valid(cdb_valid),
		.cdb_phys(cdb_phys),
		.cdb_arch(cdb_arch),
		.src_a_tag_0(src_a_tag_0),
		.src_a_ready_0(src_a_ready_0),
		.src_b_tag_0(src_b_tag_0),
		.src_b_ready_0(src_b_ready_0),
		.src_a_tag_1(src_a_tag_1),
		.src_a_ready_1(src_a_ready_1),
		.src_b_tag_1(src_b_tag_1),
		.src_b_ready_1(src_b_ready_1),
		.new_tag_0(new_tag_0),
		.new_tag_1(new_tag_1),
		.old_tag_0(old_tag_0),
		.old_tag_1(old_tag_1)
	);

endmodule

`default_nettype wire

// ==== rename.f ====
design/rename_pkg.sv
design/rename_sequencer.sv
design/fill_counter.sv
design/free_list.sv
design/map_table.sv
design/rename_unit.sv
verification/rename_tb.sv

// ==== verification/rename_tb.sv ====
`default_nettype none

module rename_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import rename_pkg::*;

	localparam int NUM_PHYS_REGS = 64;
	localparam int CDB_WIDTH = 6;
	localparam int FREE_DEPTH = NUM_PHYS_REGS - ARCH_REGS;
	localparam int RANDOM_CYCLES = 300;
	// Cycles of tests 2 to 6 with their closing idle cycles, and the final wait.
	localparam int TEST_CYCLES = 3 + 4 + 6 + (FREE_DEPTH + 7) + (RANDOM_CYCLES + 1) + 2;
	localparam int CYCLE_LIMIT = 10 + FREE_DEPTH + 2 + TEST_CYCLES + 50;

	typedef struct packed {
		logic ready;
		logic fire0;
		logic fire1;
		phys_tag_t a_tag_0;
		logic a_rdy_0;
		phys_tag_t b_tag_0;
		logic b_rdy_0;
		phys_tag_t a_tag_1;
		logic a_rdy_1;
		phys_tag_t b_tag_1;
		logic b_rdy_1;
		phys_tag_t new_0;
		phys_tag_t new_1;
		phys_tag_t old_0;
		phys_tag_t old_1;
	} expect_t;

	logic clock;
	logic reset;
	logic slot_valid_0, uses_ra_0, uses_rb_0;
	arch_reg_t ra_0, rb_0, dest_0;
	logic slot_valid_1, uses_ra_1, uses_rb_1;
	arch_reg_t ra_1, rb_1, dest_1;
	logic [CDB_WIDTH-1:0] cdb_valid;
	phys_tag_t [CDB_WIDTH-1:0] cdb_phys;
	arch_reg_t [CDB_WIDTH-1:0] cdb_arch;
	logic [1:0] retire_valid;
	phys_tag_t retire_tag0, retire_tag1;
	logic dispatch_ready;
	phys_tag_t src_a_tag_0, src_b_tag_0, new_tag_0, old_tag_0;
	phys_tag_t src_a_tag_1, src_b_tag_1, new_tag_1, old_tag_1;
	logic src_a_ready_0, src_b_ready_0, src_a_ready_1, src_b_ready_1;

	// Reference model of the rename state.
	phys_tag_t model_map [ARCH_REGS];
	logic [ARCH_REGS-1:0] model_ready;
	phys_tag_t model_free [$];
	phys_tag_t released [$];
	int fill_count;
	logic model_run;
	expect_t exp_now;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int cycle_count = 0;

	rename_unit uut (.*);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Expected outputs for the inputs of the current cycle.
	function automatic expect_t predict();
		expect_t e;
		logic byp_a;
		logic byp_b;
		e.ready = model_run && (model_free.size() >= 2);
		e.fire0 = slot_valid_0 && e.ready;
		e.fire1 = slot_valid_1 && e.ready;
		e.new_0 = (model_free.size() > 0) ? model_free[0] : '0;
		e.new_1 = e.fire0 ? model_free[1] : e.new_0;
		e.a_tag_0 = uses_ra_0 ? model_map[ra_0] : '0;
		e.a_rdy_0 = uses_ra_0 ? model_ready[ra_0] : 1'b1;
		e.b_tag_0 = uses_rb_0 ? model_map[rb_0] : '0;
		e.b_rdy_0 = uses_rb_0 ? model_ready[rb_0] : 1'b1;
		byp_a = e.fire0 && (ra_1 == dest_0);
		byp_b = e.fire0 && (rb_1 == dest_0);
		e.a_tag_1 = !uses_ra_1 ? '0 : (byp_a ? e.new_0 : model_map[ra_1]);
		e.a_rdy_1 = !uses_ra_1 || (!byp_a && model_ready[ra_1]);
		e.b_tag_1 = !uses_rb_1 ? '0 : (byp_b ? e.new_0 : model_map[rb_1]);
		e.b_rdy_1 = !uses_rb_1 || (!byp_b && model_ready[rb_1]);
		e.old_0 = model_map[dest_0];
		e.old_1 = (e.fire0 && dest_1 == dest_0) ? e.new_0 : model_map[dest_1];
		return e;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < ARCH_REGS; i++)
		begin
			model_map[i] = phys_tag_t'(i);
		end
		model_ready = '1;
		model_free.delete();
		released.delete();
		fill_count = 0;
		model_run = 1'b0;
	endtask

	// Moves the model to the state after the next rising edge.
	task automatic model_update(input expect_t e);
		for (int lane = 0; lane < CDB_WIDTH; lane++)
		begin
			if (cdb_valid[lane] && model_map[cdb_arch[lane]] == cdb_phys[lane])
			begin
				model_ready[cdb_arch[lane]] = 1'b1;
			end
		end
		if (e.fire0)
		begin
			model_ready[dest_0] = 1'b0;
			model_map[dest_0] = e.new_0;
			released.push_back(e.old_0);
			void'(model_free.pop_front());
		end
		if (e.fire1)
		begin
			model_ready[dest_1] = 1'b0;
			model_map[dest_1] = e.new_1;
			released.push_back(e.old_1);
			void'(model_free.pop_front());
		end
		if (!model_run)
		begin
			model_free.push_back(phys_tag_t'(ARCH_REGS + fill_count));
			fill_count++;
			model_run = (fill_count == FREE_DEPTH);
		end
		else
		begin
			if (retire_valid[0])
			begin
				model_free.push_back(retire_tag0);
			end
			if (retire_valid[1])
			begin
				model_free.push_back(retire_tag1);
			end
		end
	endtask

	task automatic check_tag(input string name, input phys_tag_t expected, input phys_tag_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Error: %s expected %h, got %h at cycle %0d", name, expected, actual, cycle_count);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("Error: %s expected %h, got %h at cycle %0d", name, expected, actual, cycle_count);
		end
	endtask

	task automatic compare_outputs(input expect_t e);
		check_flag("dispatch_ready", e.ready, dispatch_ready);
		check_tag("src_a_tag_0", e.a_tag_0, src_a_tag_0);
		check_flag("src_a_ready_0", e.a_rdy_0, src_a_ready_0);
		check_tag("src_b_tag_0", e.b_tag_0, src_b_tag_0);
		check_flag("src_b_ready_0", e.b_rdy_0, src_b_ready_0);
		check_tag("src_a_tag_1", e.a_tag_1, src_a_tag_1);
		check_flag("src_a_ready_1", e.a_rdy_1, src_a_ready_1);
		check_tag("src_b_tag_1", e.b_tag_1, src_b_tag_1);
		check_flag("src_b_ready_1", e.b_rdy_1, src_b_ready_1);
		check_tag("old_tag_0", e.old_0, old_tag_0);
		check_tag("old_tag_1", e.old_1, old_tag_1);
		// New tags only mean something for a slot that fires.
		if (e.fire0)
		begin
			check_tag("new_tag_0", e.new_0, new_tag_0);
		end
		if (e.fire1)
		begin
			check_tag("new_tag_1", e.new_1, new_tag_1);
		end
	endtask

	// Outputs are settled at the falling edge, half a cycle after the inputs changed.
	always @(negedge clock)
	begin
		if (reset)
		begin
			model_reset();
		end
		else
		begin
			exp_now = predict();
			compare_outputs(exp_now);
			model_update(exp_now);
		end
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Bits of uses are ra_0, rb_0, ra_1 and rb_1 from the bottom. One CDB lane is driven.
	task automatic drive(
		input logic [3:0] uses,
		input logic v0, input arch_reg_t a0, b0, d0,
		input logic v1, input arch_reg_t a1, b1, d1,
		input logic cv, input int cl, input phys_tag_t cp, input arch_reg_t ca,
		input logic [1:0] rv, input phys_tag_t rt0, rt1
	);
		@(posedge clock);
		slot_valid_0 <= v0;
		uses_ra_0 <= uses[0];
		uses_rb_0 <= uses[1];
		ra_0 <= a0;
		rb_0 <= b0;
		dest_0 <= d0;
		slot_valid_1 <= v1;
		uses_ra_1 <= uses[2];
		uses_rb_1 <= uses[3];
		ra_1 <= a1;
		rb_1 <= b1;
		dest_1 <= d1;
		cdb_valid <= CDB_WIDTH'(cv) << cl;
		cdb_phys <= {CDB_WIDTH{cp}};
		cdb_arch <= {CDB_WIDTH{ca}};
		retire_valid <= rv;
		retire_tag0 <= rt0;
		retire_tag1 <= rt1;
	endtask

	task automatic dispatch(
		input logic v0, input arch_reg_t a0, b0, d0,
		input logic v1, input arch_reg_t a1, b1, d1
	);
		drive(4'hf, v0, a0, b0, d0, v1, a1, b1, d1, 1'b0, 0, '0, '0, 2'b00, '0, '0);
	endtask

	task automatic idle();
		dispatch(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
	endtask

	task automatic random_cycle();
		logic [1:0] rv;
		phys_tag_t rt0;
		phys_tag_t rt1;
		arch_reg_t ca;
		phys_tag_t cp;
		rv = 2'b00;
		rt0 = '0;
		rt1 = '0;
		if (released.size() > 0 && ($urandom % 4) != 0)
		begin
			rv[0] = 1'b1;
			rt0 = released.pop_front();
		end
		if (released.size() > 0 && ($urandom % 2) != 0)
		begin
			rv[1] = 1'b1;
			rt1 = released.pop_front();
		end
		ca = arch_reg_t'($urandom);
		cp = (($urandom % 4) != 0) ? model_map[ca] : phys_tag_t'($urandom);
		drive(4'($urandom), (($urandom % 4) != 0), arch_reg_t'($urandom), arch_reg_t'($urandom),
			arch_reg_t'($urandom), (($urandom % 4) != 0), arch_reg_t'($urandom),
			arch_reg_t'($urandom), arch_reg_t'($urandom), 1'($urandom), $urandom % CDB_WIDTH,
			cp, ca, rv, rt0, rt1);
	endtask

	task automatic report_test(input string name, input int start);
		tests++;
		if (errors == start)
		begin
			$display("Test %0d %s: passed", tests, name);
		end
		else
		begin
			$display("Test %0d %s: failed with %0d mismatches", tests, name, errors - start);
		end
	endtask

	initial
	begin
		int start;
		int n;
		phys_tag_t stale;
		phys_tag_t rt_a;
		phys_tag_t rt_b;
		void'($urandom(32'hcddf_4827));
		reset = 1'b1;
		{slot_valid_0, uses_ra_0, uses_rb_0, ra_0, rb_0, dest_0} = '0;
		{slot_valid_1, uses_ra_1, uses_rb_1, ra_1, rb_1, dest_1} = '0;
		{cdb_valid, cdb_phys, cdb_arch} = '0;
		{retire_valid, retire_tag0, retire_tag1} = '0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;

		start = errors;
		for (n = 0; n < FREE_DEPTH + 2; n++)
		begin
			dispatch(1'b0, arch_reg_t'(n), arch_reg_t'(n + 7), arch_reg_t'(n),
				1'b0, arch_reg_t'(n + 1), arch_reg_t'(n + 3), '0);
			@(negedge clock);
			if (dispatch_ready)
			begin
				break;
			end
		end
		if (!dispatch_ready)
		begin
			errors++;
			$display("dispatch_ready did not rise after the free list fill.");
		end
		idle();
		report_test("fill", start);

		start = errors;
		dispatch(1'b1, 5'd5, 5'd6, 5'd5, 1'b0, '0, '0, '0);
		dispatch(1'b0, 5'd5, 5'd6, '0, 1'b0, 5'd5, 5'd5, '0);
		idle();
		report_test("single dispatch", start);

		start = errors;
		dispatch(1'b1, 5'd1, 5'd2, 5'd7, 1'b1, 5'd7, 5'd3, 5'd9);
		dispatch(1'b1, 5'd7, 5'd9, 5'd10, 1'b1, 5'd10, 5'd10, 5'd10);
		dispatch(1'b0, 5'd10, 5'd7, '0, 1'b0, 5'd9, 5'd10, '0);
		idle();
		report_test("pair dispatch", start);

		start = errors;
		drive(4'hf, 1'b0, 5'd5, 5'd5, '0, 1'b0, '0, '0, '0, 1'b1, 0, model_map[5], 5'd5,
			2'b00, '0, '0);
		stale = model_map[6];
		dispatch(1'b1, 5'd5, 5'd6, 5'd6, 1'b0, '0, '0, '0);
		drive(4'hf, 1'b0, 5'd6, 5'd6, '0, 1'b0, '0, '0, '0, 1'b1, CDB_WIDTH - 1, stale, 5'd6,
			2'b00, '0, '0);
		// The broadcast of the current tag of r7 meets its rename in the same cycle.
		drive(4'hf, 1'b1, 5'd1, 5'd2, 5'd7, 1'b0, '0, '0, '0, 1'b1, 2, model_map[7], 5'd7,
			2'b00, '0, '0);
		dispatch(1'b0, 5'd6, 5'd7, '0, 1'b0, 5'd5, 5'd7, '0);
		idle();
		report_test("result bus wakeup", start);

		start = errors;
		for (n = 0; n < FREE_DEPTH; n++)
		begin
			dispatch(1'b1, arch_reg_t'(n), arch_reg_t'(n + 1), arch_reg_t'(n + 11),
				1'b1, arch_reg_t'(n + 2), arch_reg_t'(n + 11), arch_reg_t'(n + 20));
			@(negedge clock);
			if (!dispatch_ready)
			begin
				break;
			end
		end
		if (dispatch_ready)
		begin
			errors++;
			$display("dispatch_ready stayed high although the free list was drained.");
		end
		repeat (2) dispatch(1'b1, 5'd3, 5'd4, 5'd3, 1'b1, 5'd4, 5'd5, 5'd6);
		repeat (2)
		begin
			rt_a = released.pop_front();
			rt_b = released.pop_front();
			drive(4'hf, 1'b0, '0, '0, '0, 1'b0, '0, '0, '0, 1'b0, 0, '0, '0, 2'b11, rt_a, rt_b);
		end
		dispatch(1'b1, 5'd12, 5'd13, 5'd14, 1'b1, 5'd14, 5'd15, 5'd16);
		dispatch(1'b1, 5'd16, 5'd17, 5'd18, 1'b1, 5'd19, 5'd18, 5'd20);
		idle();
		report_test("drain and retire", start);

		start = errors;
		for (n = 0; n < RANDOM_CYCLES; n++)
		begin
			random_cycle();
		end
		idle();
		report_test("random mix", start);

		repeat (2) @(posedge clock);
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
		begin
			$display("NO ERRORS");
		end
		else
		begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
